// File: design/bridge_settings.svh
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// --------------------------------------------------
// CPU side
// --------------------------------------------------
`define BRIDGE_ADDR_W 3 // block select from the cpu

// --------------------------------------------------
// RAM side
// --------------------------------------------------
`define BRIDGE_HALF_W 16 // one ram word
`define BRIDGE_RAM_AW (`BRIDGE_ADDR_W + 2) // block plus 2 beat bits
`define BRIDGE_RAM_DEPTH (1 << `BRIDGE_RAM_AW) // 32 entries

`endif

// File: design/bridge_pkg.sv
`include "bridge_settings.svh"

package bridge_pkg;

	// --------------------------------------------------
	// beat bookkeeping
	// --------------------------------------------------

	// index of a halfword within a 64-bit write
	typedef logic [1:0] beat_t;

	// --------------------------------------------------
	// data words
	// --------------------------------------------------

	// one entry of the narrow RAM
	typedef logic [`BRIDGE_HALF_W-1:0] halfword_t;

	// two joined halfwords, first beat in the upper half
	typedef logic [2*`BRIDGE_HALF_W-1:0] cpu_rdata_t;

endpackage

// File: design/ram_port_if.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

interface ram_port_if
	import bridge_pkg::*;
	();

	// read port
	logic [`BRIDGE_RAM_AW-1:0] raddr;
	logic re;
	halfword_t rdata; // valid one cycle after re

	// write port
	logic [`BRIDGE_RAM_AW-1:0] waddr;
	logic we;
	halfword_t wdata;

	modport seq (
		output raddr, re, // sequencer side
		output waddr, we, wdata
	);

	modport mem (
		input raddr, re,
		input waddr, we, wdata,
		output rdata
	);

	modport obs (
		input raddr, re, rdata, // monitor only
		input waddr, we, wdata
	);

endinterface

// File: design/request_decode.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module request_decode (
	input logic CLK,
	input logic RST,
	input logic read_req,
	input logic write_req,
	input logic [`BRIDGE_ADDR_W-1:0] addr,
	input logic [63:0] wdata,
	output logic rd_start,
	output logic wr_start,
	output logic [`BRIDGE_ADDR_W-1:0] req_addr,
	output logic [63:0] req_wdata
);

	logic rd_req_q; // request lines one clock late
	logic wr_req_q;

	// --------------------------------------------------
	// request edge detect
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_req_q <= 1'b0;
			wr_req_q <= 1'b1; // a line held high through reset is not an edge
		end
		else
		begin
			rd_req_q <= read_req;
			wr_req_q <= write_req;
		end
	end

	// high for the cycle before the sampling edge
	assign rd_start = read_req & ~rd_req_q;
	assign wr_start = write_req & ~wr_req_q;

	// --------------------------------------------------
	// request capture
	// --------------------------------------------------

	// the cpu is free to change addr and wdata once captured
	always_ff @(posedge CLK)
	begin
		if (rd_start || wr_start)
		begin
			req_addr <= addr; // shared by both transfers
		end
		if (wr_start)
		begin
			req_wdata <= wdata;
		end
	end

endmodule

// File: design/beat_sequencer.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module beat_sequencer
	import bridge_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic rd_start,
	input logic wr_start,
	input logic [`BRIDGE_ADDR_W-1:0] req_addr,
	input logic [63:0] req_wdata,
	ram_port_if.seq ram,
	output logic wr_ack,
	output logic rd_beat_valid,
	output beat_t rd_beat,
	output logic rd_done
);

	logic wr_active;
	beat_t wr_cnt; // halfword being written
	logic rd_active;
	logic rd_cnt; // only two read beats

	// --------------------------------------------------
	// write beats
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_active <= 1'b0;
			wr_cnt <= '0;
			wr_ack <= 1'b0;
		end
		else if (wr_start)
		begin
			wr_active <= 1'b1; // restarts a running write too
			wr_cnt <= '0;
			wr_ack <= 1'b0;
		end
		else if (wr_active)
		begin
			wr_cnt <= wr_cnt + 2'd1;
			if (wr_cnt == 2'd3)
			begin
				wr_active <= 1'b0;
				wr_ack <= 1'b1; // held until the next write edge
			end
		end
	end

	assign ram.we = wr_active;
	assign ram.waddr = {req_addr, wr_cnt};

	// highest halfword goes out first
	always_comb
	begin
		case (wr_cnt)
			2'd0: ram.wdata = req_wdata[63:48];
			2'd1: ram.wdata = req_wdata[47:32];
			2'd2: ram.wdata = req_wdata[31:16];
			default: ram.wdata = req_wdata[15:0];
		endcase
	end

	// --------------------------------------------------
	// read beats
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_active <= 1'b0;
			rd_cnt <= 1'b0;
			rd_beat_valid <= 1'b0;
			rd_beat <= '0;
			rd_done <= 1'b0;
		end
		else
		begin
			if (rd_start)
			begin
				rd_active <= 1'b1;
				rd_cnt <= 1'b0;
			end
			else if (rd_active)
			begin
				rd_cnt <= ~rd_cnt;
				rd_active <= ~rd_cnt; // stop after beat 1
			end
			rd_beat_valid <= rd_active; // tag lines up with rdata
			rd_beat <= {1'b0, rd_cnt};
			rd_done <= rd_active & rd_cnt;
		end
	end

	assign ram.re = rd_active;
	assign ram.raddr = {req_addr, 1'b0, rd_cnt}; // halfwords 0 and 1 of the block

endmodule

// File: design/halfword_ram.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module halfword_ram
	import bridge_pkg::*;
(
	input logic CLK,
	ram_port_if.mem ram
);

	halfword_t mem [0:`BRIDGE_RAM_DEPTH-1];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (ram.we)
		begin
			mem[ram.waddr] <= ram.wdata;
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------

	// same-address collision returns the old word
	always_ff @(posedge CLK)
	begin
		if (ram.re)
		begin
			ram.rdata <= mem[ram.raddr]; // one cycle latency
		end
	end

endmodule

// File: design/read_assembler.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module read_assembler
	import bridge_pkg::*;
(
	input logic CLK,
	input logic RST,
	ram_port_if.obs ram,
	input logic rd_beat_valid,
	input beat_t rd_beat,
	input logic rd_done,
	input logic rd_start,
	output cpu_rdata_t rd_data,
	output logic rd_ack
);

	// --------------------------------------------------
	// word assembly
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_data <= '0;
		end
		else if (rd_beat_valid)
		begin
			if (rd_beat == 2'd0)
			begin
				rd_data[2*`BRIDGE_HALF_W-1:`BRIDGE_HALF_W] <= ram.rdata; // upper half
			end
			else
			begin
				rd_data[`BRIDGE_HALF_W-1:0] <= ram.rdata; // lower half
			end
		end
	end

	// --------------------------------------------------
	// acknowledge
	// --------------------------------------------------

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			rd_ack <= 1'b0;
		end
		else if (rd_start)
		begin
			rd_ack <= 1'b0; // new request drops it
		end
		else if (rd_done)
		begin
			rd_ack <= 1'b1;
		end
	end

endmodule

// File: design/mem_bridge_top.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module mem_bridge_top
	import bridge_pkg::*;
(
	input logic CLK,
	input logic RST,
	input logic READ_CPU,
	input logic WRITE_CPU,
	output logic READ_CPU_ACK,
	output logic WRITE_CPU_ACK,
	input logic [`BRIDGE_ADDR_W-1:0] ADDR_CPU,
	input logic [63:0] IN_CPU,
	output logic [31:0] OUT_CPU
);

	logic rd_start;
	logic wr_start;
	logic [`BRIDGE_ADDR_W-1:0] req_addr;
	logic [63:0] req_wdata;
	logic rd_beat_valid;
	beat_t rd_beat;
	logic rd_done;

	ram_port_if ram_bus ();

	// --------------------------------------------------
	// decode, execute, memory, result
	// --------------------------------------------------

	request_decode u_decode (
		.CLK(CLK),
		.RST(RST),
		.read_req(READ_CPU),
		.write_req(WRITE_CPU),
		.addr(ADDR_CPU),
		.wdata(IN_CPU),
		.rd_start(rd_start),
		.wr_start(wr_start),
		.req_addr(req_addr),
		.req_wdata(req_wdata)
	);

	beat_sequencer u_seq (
		.CLK(CLK),
		.RST(RST),
		.rd_start(rd_start),
		.wr_start(wr_start),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.ram(ram_bus.seq),
		.wr_ack(WRITE_CPU_ACK),
		.rd_beat_valid(rd_beat_valid),
		.rd_beat(rd_beat),
		.rd_done(rd_done)
	);

	halfword_ram u_ram (
		.CLK(CLK),
		.ram(ram_bus.mem)
	);

	read_assembler u_asm (
		.CLK(CLK),
		.RST(RST),
		.ram(ram_bus.obs),
		.rd_beat_valid(rd_beat_valid),
		.rd_beat(rd_beat),
		.rd_done(rd_done),
		.rd_start(rd_start),
		.rd_data(OUT_CPU),
		.rd_ack(READ_CPU_ACK)
	);

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
	output logic CLK,
	output logic RST
);

	localparam int HALF_PERIOD = 5; // 10 ns clock
	localparam int RESET_CYCLES = 2;

	initial
	begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// released on a falling edge like every other input
	initial
	begin
		RST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
	end

endmodule

// File: test/mem_bridge_asserts.sv
`timescale 1ns/10ps

module mem_bridge_asserts (
	input logic CLK,
	input logic RST,
	input logic read_cpu,
	input logic write_cpu,
	input logic read_ack,
	input logic write_ack,
	input logic [31:0] out_cpu,
	input logic we,
	input logic re
);

	logic failed = 1'b0; // watched by the testbench

	// --------------------------------------------------
	// reset values
	// --------------------------------------------------

	a_reset_outputs: assert property (@(posedge CLK)
		!RST |=> !read_ack && !write_ack && out_cpu == '0)
	else
	begin
		failed = 1'b1;
		$error("acknowledges or read word not cleared by reset");
	end

	a_reset_ram_ports: assert property (@(posedge CLK) !RST |=> !we && !re)
	else
	begin
		failed = 1'b1;
		$error("ram enables not cleared by reset");
	end

	// --------------------------------------------------
	// write acknowledge
	// --------------------------------------------------

	a_write_latency: assert property (@(posedge CLK) disable iff (!RST)
		$rose(write_cpu) |=> !write_ack [*4] ##1 write_ack)
	else
	begin
		failed = 1'b1;
		$error("write acknowledge not 5 cycles after the request edge");
	end

	a_write_ack_holds: assert property (@(posedge CLK) disable iff (!RST)
		write_ack && !$rose(write_cpu) |=> write_ack)
	else
	begin
		failed = 1'b1;
		$error("write acknowledge dropped without a new request");
	end

	// a line held high through reset is no request
	a_write_ack_needs_edge: assert property (@(posedge CLK) disable iff (!RST)
		$rose(write_ack) |-> $past(write_cpu, 5) && !$past(write_cpu, 6))
	else
	begin
		failed = 1'b1;
		$error("write acknowledge rose without a write request edge");
	end

	// --------------------------------------------------
	// read acknowledge
	// --------------------------------------------------

	a_read_latency: assert property (@(posedge CLK) disable iff (!RST)
		$rose(read_cpu) |=> !read_ack [*3] ##1 read_ack)
	else
	begin
		failed = 1'b1;
		$error("read acknowledge not 4 cycles after the request edge");
	end

	a_read_ack_holds: assert property (@(posedge CLK) disable iff (!RST)
		read_ack && !$rose(read_cpu) |=> read_ack)
	else
	begin
		failed = 1'b1;
		$error("read acknowledge dropped without a new request");
	end

	a_read_ack_needs_edge: assert property (@(posedge CLK) disable iff (!RST)
		$rose(read_ack) |-> $past(read_cpu, 4) && !$past(read_cpu, 5))
	else
	begin
		failed = 1'b1;
		$error("read acknowledge rose without a read request edge");
	end

endmodule

// File: test/tb_mem_bridge.sv
`include "bridge_settings.svh"
`timescale 1ns/10ps

module tb_mem_bridge;

	localparam logic [31:0] SEED = 32'h4c6bd636;
	localparam int NUM_BLOCKS = 1 << `BRIDGE_ADDR_W;
	localparam int NUM_RANDOM = 24; // mixed reads and writes
	localparam int NUM_PAIRS = 4; // read and write started together
	localparam int NUM_TRANS = 2 * NUM_BLOCKS + NUM_RANDOM + 2 * NUM_PAIRS + 1;
	localparam int TIMEOUT_CYCLES = NUM_TRANS * 20 + 100;
	localparam int ACK_LIMIT = 12; // cycles one transfer may take

	logic CLK;
	logic RST;
	logic read_cpu;
	logic write_cpu;
	logic read_ack;
	logic write_ack;
	logic [`BRIDGE_ADDR_W-1:0] addr_cpu;
	logic [63:0] in_cpu;
	logic [31:0] out_cpu;

	logic [31:0] upper_model [NUM_BLOCKS]; // bits 63:32 of the last write

	tb_clock_gen u_clk (
		.CLK(CLK),
		.RST(RST)
	);

	mem_bridge_top dut (
		.CLK(CLK),
		.RST(RST),
		.READ_CPU(read_cpu),
		.WRITE_CPU(write_cpu),
		.READ_CPU_ACK(read_ack),
		.WRITE_CPU_ACK(write_ack),
		.ADDR_CPU(addr_cpu),
		.IN_CPU(in_cpu),
		.OUT_CPU(out_cpu)
	);

	bind mem_bridge_top mem_bridge_asserts u_asserts (
		.CLK(CLK),
		.RST(RST),
		.read_cpu(READ_CPU),
		.write_cpu(WRITE_CPU),
		.read_ack(READ_CPU_ACK),
		.write_ack(WRITE_CPU_ACK),
		.out_cpu(OUT_CPU),
		.we(ram_bus.we),
		.re(ram_bus.re)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	task automatic abort_run;
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_word(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERR %s: expected %h, actual %h", test_name, expected, actual);
			abort_run();
		end
	endtask

	// called right after the request lines were raised on a falling edge
	task automatic await_acks(input string test_name, input bit need_read,
		input bit need_write);
		int waited;
		waited = 0;
		@(posedge CLK); // request edge clears the old acknowledge
		@(negedge CLK);
		while ((need_read && !read_ack) || (need_write && !write_ack))
		begin
			waited++;
			if (waited > ACK_LIMIT)
			begin
				$display("%s: no acknowledge within %0d cycles of the request",
					test_name, ACK_LIMIT);
				abort_run();
			end
			@(negedge CLK);
		end
	endtask

	task automatic write_block(input string test_name, input logic [`BRIDGE_ADDR_W-1:0] a,
		input logic [63:0] d);
		addr_cpu = a;
		in_cpu = d;
		write_cpu = 1'b1;
		await_acks(test_name, 1'b0, 1'b1);
		upper_model[a] = d[63:32];
		write_cpu = 1'b0;
		@(negedge CLK); // low for one edge before the next request
	endtask

	task automatic read_block(input string test_name, input logic [`BRIDGE_ADDR_W-1:0] a);
		addr_cpu = a;
		read_cpu = 1'b1;
		await_acks(test_name, 1'b1, 1'b0);
		check_word(test_name, upper_model[a], out_cpu);
		read_cpu = 1'b0;
		@(negedge CLK);
	endtask

	// one address bus, so both transfers hit the same block
	task automatic read_write_pair(input string test_name,
		input logic [`BRIDGE_ADDR_W-1:0] a, input logic [63:0] d);
		logic [31:0] old_word;
		old_word = upper_model[a];
		addr_cpu = a;
		in_cpu = d;
		read_cpu = 1'b1;
		write_cpu = 1'b1;
		await_acks(test_name, 1'b1, 1'b1);
		check_word(test_name, old_word, out_cpu); // read beats see the old halfwords
		upper_model[a] = d[63:32];
		read_cpu = 1'b0;
		write_cpu = 1'b0;
		@(negedge CLK);
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------

	initial
	begin
		int i;
		int j;
		logic [`BRIDGE_ADDR_W-1:0] tmp;
		logic [`BRIDGE_ADDR_W-1:0] order [NUM_BLOCKS];

		void'($urandom(SEED));
		read_cpu = 1'b0;
		write_cpu = 1'b1; // held high through reset
		addr_cpu = '0;
		in_cpu = '0;

		wait (RST === 1'b1);
		repeat (8) @(negedge CLK);
		check_word("reset_hold", 32'd0, {31'd0, write_ack});
		write_cpu = 1'b0;
		@(negedge CLK);

		for (i = 0; i < NUM_BLOCKS; i++)
		begin
			write_block("fill_all", `BRIDGE_ADDR_W'(i), {$urandom, $urandom});
		end

		for (i = 0; i < NUM_BLOCKS; i++)
		begin
			order[i] = `BRIDGE_ADDR_W'(i);
		end
		for (i = NUM_BLOCKS - 1; i > 0; i--)
		begin
			j = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (i = 0; i < NUM_BLOCKS; i++)
		begin
			read_block("readback_shuffled", order[i]);
		end

		for (i = 0; i < NUM_RANDOM; i++)
		begin
			tmp = `BRIDGE_ADDR_W'($urandom_range(NUM_BLOCKS - 1, 0));
			if ($urandom_range(1, 0) == 1)
			begin
				write_block("random_mix", tmp, {$urandom, $urandom});
			end
			else
			begin
				read_block("random_mix", tmp);
			end
		end

		for (i = 0; i < NUM_PAIRS; i++)
		begin
			tmp = `BRIDGE_ADDR_W'($urandom_range(NUM_BLOCKS - 1, 0));
			read_write_pair("read_with_write", tmp, {$urandom, $urandom});
			read_block("read_with_write", tmp); // new data visible afterwards
		end

		repeat (4) @(negedge CLK);
		if (dut.u_asserts.failed !== 1'b0)
		begin
			$display("a protocol assertion failed during the run");
			abort_run();
		end
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// a failed concurrent assertion ends the run right away
	initial
	begin
		wait (dut.u_asserts.failed === 1'b1);
		$display("protocol assertion failed, see the error above");
		abort_run();
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		abort_run();
	end

endmodule

// File: sources.f
+incdir+design
design/bridge_pkg.sv
design/ram_port_if.sv
design/request_decode.sv
design/beat_sequencer.sv
design/halfword_ram.sv
design/read_assembler.sv
design/mem_bridge_top.sv
test/tb_clock_gen.sv
test/mem_bridge_asserts.sv
test/tb_mem_bridge.sv

// File: Bender.yml
package:
  name: mem_bridge

sources:
  - include_dirs:
      - design
    files:
      - design/bridge_pkg.sv
      - design/ram_port_if.sv
      - design/request_decode.sv
      - design/beat_sequencer.sv
      - design/halfword_ram.sv
      - design/read_assembler.sv
      - design/mem_bridge_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_clock_gen.sv
      - test/mem_bridge_asserts.sv
      - test/tb_mem_bridge.sv
